/* common/ldu_pkg.sv */
// Load unit package
// Shared data types, opcode and FSM encodings, protected region bounds
// and store buffer sizing for the memory stage load path

package ldu_pkg;

    // ----------------------------
    // Data types
    // ----------------------------

    // Full data word moved by loads and stores
    typedef logic [31:0] data_word_t;

    // Byte address seen by the load and store channels
    typedef logic [31:0] addr_t;

    // Load width
    // Bit 1 of the byte address picks a halfword and bits 1:0 pick a byte
    typedef enum logic [1:0] {
        LDB = 2'b00,
        LDH = 2'b01,
        LDW = 2'b10
    } ldu_op_e;

    // Load control FSM states
    typedef enum logic [1:0] {
        IDLE        = 2'b00,
        WAIT_DRAIN  = 2'b01,
        WAIT_MEMORY = 2'b10,
        RESPOND     = 2'b11
    } ldu_state_e;

    // ----------------------------
    // Constants
    // ----------------------------

    // Protected region with inclusive bounds that only machine mode may read
    localparam addr_t PRIV_REGION_START = 32'h0000_F000;
    localparam addr_t PRIV_REGION_END   = 32'h0000_FFFF;

    // Store buffer depth must be a power of two so the pointers wrap naturally
    localparam int SB_DEPTH = 4;
    localparam int SB_PTR_W = $clog2(SB_DEPTH);

    // Source of the word that feeds the slicer
    localparam logic [1:0] SEL_FWD   = 2'd0;
    localparam logic [1:0] SEL_MEM   = 2'd1;
    localparam logic [1:0] SEL_SAVED = 2'd2;

endpackage : ldu_pkg

/* design/load_unit/load_access_check.sv */
// Load access check
// Flags misaligned loads and user-mode loads into the protected region

`timescale 1ns/1ps

module load_access_check (
    input  logic             load_valid_i,
    input  ldu_pkg::ldu_op_e load_op_i,
    input  ldu_pkg::addr_t   load_addr_i,
    input  logic             privilege_i,
    output logic             misaligned_o,
    output logic             illegal_access_o,
    output logic             exc_o
);

    logic misaligned;
    logic in_region;

    // Byte loads are always aligned
    always_comb begin
        case (load_op_i)
            ldu_pkg::LDH: misaligned = load_addr_i[0];
            ldu_pkg::LDW: misaligned = (load_addr_i[1:0] != 2'b00);
            default:      misaligned = 1'b0;
        endcase
    end

    assign in_region = (load_addr_i >= ldu_pkg::PRIV_REGION_START) &&
                       (load_addr_i <= ldu_pkg::PRIV_REGION_END);

    // Only machine mode (privilege 1) may read the protected region
    assign misaligned_o     = misaligned & load_valid_i;
    assign illegal_access_o = in_region & ~privilege_i & load_valid_i;

    assign exc_o = misaligned_o | illegal_access_o;

endmodule : load_access_check

/* design/load_unit/load_control.sv */
// Load control FSM
// Steers each accepted load down the exception, forwarding, drain-wait
// or memory path and holds the result while the pipeline is stalled

`timescale 1ns/1ps

module load_control (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              load_valid_i,
    input  ldu_pkg::ldu_op_e  load_op_i,
    input  logic              exc_i,
    input  logic              fwd_hit_i,
    input  logic              sb_empty_i,
    input  logic              mem_load_valid_i,
    output logic              capture_o,
    output logic [1:0]        sel_o,
    output logic              mem_load_req_o,
    output logic              load_data_valid_o,
    output logic              idle_o,
    output logic              exc_zero_o
);

    ldu_pkg::ldu_state_e state_q;
    ldu_pkg::ldu_state_e state_d;

    // ----------------------------
    // State register
    // ----------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ldu_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // The unit takes a new load only from IDLE
    assign idle_o = (state_q == ldu_pkg::IDLE);

    // ----------------------------
    // Next state and outputs
    // ----------------------------

    always_comb begin
        state_d           = state_q;
        capture_o         = 1'b0;
        sel_o             = ldu_pkg::SEL_SAVED;
        mem_load_req_o    = 1'b0;
        load_data_valid_o = 1'b0;
        exc_zero_o        = 1'b0;

        case (state_q)
            ldu_pkg::IDLE: begin
                if (load_valid_i) begin
                    if (exc_i) begin
                        // Faulting loads answer at once with a zero result
                        load_data_valid_o = 1'b1;
                        exc_zero_o        = 1'b1;
                    end else if (fwd_hit_i && (load_op_i == ldu_pkg::LDW)) begin
                        // The buffered word is saved now and returned next cycle
                        capture_o = 1'b1;
                        sel_o     = ldu_pkg::SEL_FWD;
                        state_d   = ldu_pkg::RESPOND;
                    end else if (sb_empty_i) begin
                        capture_o      = 1'b1;
                        mem_load_req_o = 1'b1;
                        state_d        = ldu_pkg::WAIT_MEMORY;
                    end else begin
                        // Pending stores may overlap the load, so memory must see them first
                        capture_o = 1'b1;
                        state_d   = ldu_pkg::WAIT_DRAIN;
                    end
                end
            end

            ldu_pkg::WAIT_DRAIN: begin
                if (sb_empty_i) begin
                    mem_load_req_o = 1'b1;
                    state_d        = ldu_pkg::WAIT_MEMORY;
                end
            end

            ldu_pkg::WAIT_MEMORY: begin
                // The memory word is copied into the saved register every cycle here
                sel_o = ldu_pkg::SEL_MEM;
                if (mem_load_valid_i) begin
                    if (stall_i) begin
                        state_d = ldu_pkg::RESPOND;
                    end else begin
                        load_data_valid_o = 1'b1;
                        state_d           = ldu_pkg::IDLE;
                    end
                end
            end

            ldu_pkg::RESPOND: begin
                // Saved word is replayed once the stall clears
                if (!stall_i) begin
                    load_data_valid_o = 1'b1;
                    state_d           = ldu_pkg::IDLE;
                end
            end

            default: begin
                state_d = ldu_pkg::IDLE;
            end
        endcase
    end

endmodule : load_control

/* design/load_unit/load_align.sv */
// Load data alignment
// Holds the accepted load, picks the source word and slices and extends it

`timescale 1ns/1ps

module load_align (
    input  logic                clk_i,
    input  logic                capture_i,
    input  ldu_pkg::ldu_op_e    load_op_i,
    input  logic                load_signed_i,
    input  ldu_pkg::addr_t      load_addr_i,
    input  logic [1:0]          sel_i,
    input  ldu_pkg::data_word_t fwd_data_i,
    input  ldu_pkg::data_word_t mem_load_data_i,
    input  logic                zero_i,
    output ldu_pkg::addr_t      mem_load_addr_o,
    output ldu_pkg::data_word_t load_data_o
);

    ldu_pkg::ldu_op_e    op_q;
    logic                signed_q;
    ldu_pkg::addr_t      addr_q;
    ldu_pkg::data_word_t saved_q;
    ldu_pkg::data_word_t word_sel;
    ldu_pkg::data_word_t sliced;
    logic [7:0]          byte_val;
    logic [15:0]         half_val;

    // Operation fields are latched on acceptance
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            op_q     <= load_op_i;
            signed_q <= load_signed_i;
            addr_q   <= load_addr_i;
        end
    end

    // The saved word follows the selected source until the FSM starts replaying it
    always_ff @(posedge clk_i) begin
        if (sel_i != ldu_pkg::SEL_SAVED) begin
            saved_q <= word_sel;
        end
    end

    // On the acceptance cycle the request must carry the live address
    assign mem_load_addr_o = capture_i ? load_addr_i : addr_q;

    always_comb begin
        case (sel_i)
            ldu_pkg::SEL_FWD: word_sel = fwd_data_i;
            ldu_pkg::SEL_MEM: word_sel = mem_load_data_i;
            default:          word_sel = saved_q;
        endcase
    end

    assign byte_val = word_sel[{addr_q[1:0], 3'b000} +: 8];
    assign half_val = word_sel[{addr_q[1], 4'b0000} +: 16];

    always_comb begin
        case (op_q)
            ldu_pkg::LDB: sliced = signed_q ? {{24{byte_val[7]}}, byte_val} : {24'h0, byte_val};
            ldu_pkg::LDH: sliced = signed_q ? {{16{half_val[15]}}, half_val} : {16'h0, half_val};
            default:      sliced = word_sel;
        endcase
    end

    assign load_data_o = zero_i ? '0 : sliced;

endmodule : load_align

/* design/store_buffer.sv */
// Store buffer
// Circular FIFO of word stores with youngest-entry load forwarding,
// drained to the memory store channel one entry at a time

`timescale 1ns/1ps

module store_buffer (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                store_valid_i,
    input  ldu_pkg::addr_t      store_addr_i,
    input  ldu_pkg::data_word_t store_data_i,
    input  ldu_pkg::addr_t      load_addr_i,
    input  logic                mem_store_done_i,
    output logic                store_full_o,
    output logic                empty_o,
    output logic                fwd_hit_o,
    output ldu_pkg::data_word_t fwd_data_o,
    output logic                mem_store_req_o,
    output ldu_pkg::addr_t      mem_store_addr_o,
    output ldu_pkg::data_word_t mem_store_data_o
);

    ldu_pkg::addr_t      addr_q [ldu_pkg::SB_DEPTH];
    ldu_pkg::data_word_t data_q [ldu_pkg::SB_DEPTH];

    // Head is the oldest entry, tail the next free slot
    logic [ldu_pkg::SB_PTR_W-1:0] head_q;
    logic [ldu_pkg::SB_PTR_W-1:0] tail_q;
    logic [ldu_pkg::SB_PTR_W:0]   count_q;
    logic                         outstanding_q;
    logic [ldu_pkg::SB_PTR_W-1:0] fwd_idx;
    logic                         pop;

    // ----------------------------
    // Entry storage
    // ----------------------------

    always_ff @(posedge clk_i) begin
        if (store_valid_i) begin
            addr_q[tail_q] <= store_addr_i;
            data_q[tail_q] <= store_data_i;
        end
    end

    // An entry leaves only when memory confirms its write
    assign pop = outstanding_q & mem_store_done_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            count_q       <= '0;
            outstanding_q <= 1'b0;
        end else begin
            if (store_valid_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + store_valid_i - pop;
            if (mem_store_req_o) begin
                outstanding_q <= 1'b1;
            end else if (mem_store_done_i) begin
                outstanding_q <= 1'b0;
            end
        end
    end

    assign store_full_o = (count_q == (ldu_pkg::SB_PTR_W+1)'(ldu_pkg::SB_DEPTH));
    assign empty_o      = (count_q == '0);

    // ----------------------------
    // Drain to memory
    // ----------------------------

    // Request lasts one cycle because the outstanding flag rises right after it
    assign mem_store_req_o  = ~empty_o & ~outstanding_q;
    assign mem_store_addr_o = addr_q[head_q];
    assign mem_store_data_o = data_q[head_q];

    // ----------------------------
    // Forwarding search
    // ----------------------------

    // Walk back from the youngest entry and stop at the first word match
    always_comb begin
        fwd_hit_o  = 1'b0;
        fwd_data_o = '0;
        fwd_idx    = '0;
        for (int k = 0; k < ldu_pkg::SB_DEPTH; k++) begin
            fwd_idx = tail_q - ldu_pkg::SB_PTR_W'(k + 1);
            if (!fwd_hit_o && ((ldu_pkg::SB_PTR_W+1)'(k) < count_q) &&
                (addr_q[fwd_idx][31:2] == load_addr_i[31:2])) begin
                fwd_hit_o  = 1'b1;
                fwd_data_o = data_q[fwd_idx];
            end
        end
    end

endmodule : store_buffer

/* design/load_path_top.sv */
// Load path top level
// Joins the load FSM, alignment, access check and store buffer

`timescale 1ns/1ps

module load_path_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                stall_i,
    input  logic                load_valid_i,
    input  ldu_pkg::ldu_op_e    load_op_i,
    input  logic                load_signed_i,
    input  ldu_pkg::addr_t      load_addr_i,
    input  logic                privilege_i,
    input  logic                store_valid_i,
    input  ldu_pkg::addr_t      store_addr_i,
    input  ldu_pkg::data_word_t store_data_i,
    input  logic                mem_load_valid_i,
    input  ldu_pkg::data_word_t mem_load_data_i,
    input  logic                mem_store_done_i,
    output ldu_pkg::data_word_t load_data_o,
    output logic                load_data_valid_o,
    output logic                misaligned_o,
    output logic                illegal_access_o,
    output logic                idle_o,
    output logic                store_full_o,
    output logic                mem_load_req_o,
    output ldu_pkg::addr_t      mem_load_addr_o,
    output logic                mem_store_req_o,
    output ldu_pkg::addr_t      mem_store_addr_o,
    output ldu_pkg::data_word_t mem_store_data_o
);

    logic                exc;
    logic                fwd_hit;
    ldu_pkg::data_word_t fwd_data;
    logic                sb_empty;
    logic                capture;
    logic [1:0]          sel;
    logic                exc_zero;

    load_access_check u_access_check (
        .load_valid_i, .load_op_i, .load_addr_i, .privilege_i,
        .misaligned_o, .illegal_access_o, .exc_o (exc)
    );

    load_control u_load_control (
        .clk_i, .rst_n_i, .stall_i, .load_valid_i, .load_op_i,
        .exc_i (exc), .fwd_hit_i (fwd_hit), .sb_empty_i (sb_empty), .mem_load_valid_i,
        .capture_o (capture), .sel_o (sel), .mem_load_req_o, .load_data_valid_o,
        .idle_o, .exc_zero_o (exc_zero)
    );

    load_align u_load_align (
        .clk_i, .capture_i (capture), .load_op_i, .load_signed_i, .load_addr_i,
        .sel_i (sel), .fwd_data_i (fwd_data), .mem_load_data_i, .zero_i (exc_zero),
        .mem_load_addr_o, .load_data_o
    );

    // Store buffer sees the live load address so forwarding resolves on acceptance
    store_buffer u_store_buffer (
        .clk_i, .rst_n_i, .store_valid_i, .store_addr_i, .store_data_i, .load_addr_i,
        .mem_store_done_i, .store_full_o, .empty_o (sb_empty), .fwd_hit_o (fwd_hit),
        .fwd_data_o (fwd_data), .mem_store_req_o, .mem_store_addr_o, .mem_store_data_o
    );

endmodule : load_path_top

/* tb/tb_clock_gen.sv */
// Testbench clock and reset source
// 40 ns clock period, reset held low for the first 8 cycles

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Release lands just after an edge, like every other driven input
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

/* tb/load_path_props.sv */
// Load path protocol assertions
// Input rules of the load and store ports and timing of the load request

`timescale 1ns/1ps

module load_path_props (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                load_valid_i,
    input logic                idle_i,
    input logic                store_valid_i,
    input logic                store_full_i,
    input logic                mem_load_req_i,
    input ldu_pkg::ldu_state_e state_i
);

    // A new load may only arrive while the unit is idle
    load_only_when_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) load_valid_i |-> idle_i
    ) else $error("load_valid_i asserted while the load unit is busy");

    // The store buffer has no room to absorb a write while full
    store_only_when_room: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) store_valid_i |-> !store_full_i
    ) else $error("store_valid_i asserted while the store buffer is full");

    // Memory is asked for data on acceptance or when a drain wait ends
    load_req_states: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_load_req_i |-> (state_i == ldu_pkg::IDLE || state_i == ldu_pkg::WAIT_DRAIN)
    ) else $error("mem_load_req_o raised outside IDLE and WAIT_DRAIN");

endmodule : load_path_props

/* tb/load_path_tb.sv */
// Load path testbench
// Replays store and load patterns from a file against a memory model
// with random latency and checks every load result and flag

`timescale 1ns/1ps

module load_path_tb;

    logic                clk_i;
    logic                rst_n_i;
    logic                stall_i;
    logic                load_valid_i;
    ldu_pkg::ldu_op_e    load_op_i;
    logic                load_signed_i;
    ldu_pkg::addr_t      load_addr_i;
    logic                privilege_i;
    logic                store_valid_i;
    ldu_pkg::addr_t      store_addr_i;
    ldu_pkg::data_word_t store_data_i;
    logic                mem_load_valid_i;
    ldu_pkg::data_word_t mem_load_data_i;
    logic                mem_store_done_i;
    ldu_pkg::data_word_t load_data_o;
    logic                load_data_valid_o;
    logic                misaligned_o;
    logic                illegal_access_o;
    logic                idle_o;
    logic                store_full_o;
    logic                mem_load_req_o;
    ldu_pkg::addr_t      mem_load_addr_o;
    logic                mem_store_req_o;
    ldu_pkg::addr_t      mem_store_addr_o;
    ldu_pkg::data_word_t mem_store_data_o;

    // Words written by drained stores are kept here by word address
    ldu_pkg::data_word_t mem [ldu_pkg::addr_t];
    int                  seed = 32'hc04b_a0b3;
    ldu_pkg::addr_t      ld_addr;
    int                  ld_lat;
    ldu_pkg::addr_t      st_addr;
    ldu_pkg::data_word_t st_data;
    int                  st_lat;
    int                  mismatch_count = 0;
    int                  fault_count = 0;

    tb_clock_gen u_clock_gen (.clk_o (clk_i), .rst_n_o (rst_n_i));

    load_path_top dut0 (.*);

    bind load_path_top load_path_props u_props (
        .clk_i, .rst_n_i, .load_valid_i, .idle_i (idle_o), .store_valid_i,
        .store_full_i (store_full_o), .mem_load_req_i (mem_load_req_o),
        .state_i (u_load_control.state_q)
    );

    function automatic ldu_pkg::data_word_t mem_read(input ldu_pkg::addr_t addr);
        ldu_pkg::addr_t word_addr;
        word_addr = {2'b00, addr[31:2]};
        if (mem.exists(word_addr)) begin
            return mem[word_addr];
        end
        return word_addr ^ 32'hA5A5_0000;
    endfunction

    task automatic check_word(input string name, input ldu_pkg::data_word_t exp_val,
                              input ldu_pkg::data_word_t act_val);
        if (act_val !== exp_val) begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp_val, act_val);
        end
    endtask

    // ----------------------------
    // Memory model
    // ----------------------------

    // Requests are seen at the falling edge and answered 1 to 4 cycles later
    initial begin : load_channel
        forever begin
            @(negedge clk_i);
            if (mem_load_req_o) begin
                ld_addr = mem_load_addr_o;
                ld_lat  = ($random(seed) & 3) + 1;
                repeat (ld_lat) @(posedge clk_i);
                #2;
                mem_load_data_i  = mem_read(ld_addr);
                mem_load_valid_i = 1'b1;
                @(posedge clk_i);
                #2;
                mem_load_valid_i = 1'b0;
            end
        end
    end

    initial begin : store_channel
        forever begin
            @(negedge clk_i);
            if (mem_store_req_o) begin
                st_addr = mem_store_addr_o;
                st_data = mem_store_data_o;
                st_lat  = ($random(seed) & 3) + 1;
                repeat (st_lat) @(posedge clk_i);
                #2;
                mem[{2'b00, st_addr[31:2]}] = st_data;
                mem_store_done_i = 1'b1;
                @(posedge clk_i);
                #2;
                mem_store_done_i = 1'b0;
            end
        end
    end

    // ----------------------------
    // Stimulus tasks
    // ----------------------------

    task automatic run_store(input ldu_pkg::addr_t addr, input ldu_pkg::data_word_t data);
        int cyc;
        cyc = 0;
        @(negedge clk_i);
        while (store_full_o && cyc < 200) begin
            @(negedge clk_i);
            cyc++;
        end
        @(posedge clk_i);
        #2;
        if (store_full_o) begin
            fault_count++;
            $display("timeout at %0t: store buffer stayed full for 200 cycles", $time);
        end else begin
            store_valid_i = 1'b1;
            store_addr_i  = addr;
            store_data_i  = data;
            @(posedge clk_i);
            #2;
            store_valid_i = 1'b0;
        end
    endtask

    task automatic run_load(input logic [1:0] op, input logic sgn, input logic priv,
                            input ldu_pkg::addr_t addr, input ldu_pkg::data_word_t exp_data,
                            input logic exp_mis, input logic exp_ill, input int stall);
        int   cyc;
        logic got;
        logic exc;
        logic held;
        cyc  = 0;
        got  = 1'b0;
        held = 1'b0;
        exc  = exp_mis | exp_ill;
        @(negedge clk_i);
        while (!idle_o && cyc < 200) begin
            @(negedge clk_i);
            cyc++;
        end
        if (!idle_o) begin
            fault_count++;
            $display("timeout at %0t: load unit never returned to idle", $time);
        end
        @(posedge clk_i);
        #2;
        load_valid_i  = 1'b1;
        load_op_i     = ldu_pkg::ldu_op_e'(op);
        load_signed_i = sgn;
        load_addr_i   = addr;
        privilege_i   = priv;
        stall_i       = (stall > 0);
        cyc = 0;
        while (!got && cyc < 200) begin
            @(negedge clk_i);
            if (cyc == 0) begin
                check_flag("misaligned_o", exp_mis, misaligned_o);
                check_flag("illegal_access_o", exp_ill, illegal_access_o);
                if (exc) begin
                    // Faulting loads answer in the acceptance cycle without touching memory
                    check_flag("load_data_valid_o", 1'b1, load_data_valid_o);
                    check_flag("mem_load_req_o", 1'b0, mem_load_req_o);
                end
            end
            if (stall_i && !exc) begin
                check_flag("load_data_valid_o", 1'b0, load_data_valid_o);
            end
            // A word returned during the stall is due in the first cycle without stall
            if (!stall_i && held) begin
                check_flag("load_data_valid_o", 1'b1, load_data_valid_o);
                held = 1'b0;
            end
            if (stall_i && mem_load_valid_i) begin
                held = 1'b1;
            end
            if (load_data_valid_o) begin
                got = 1'b1;
                check_word("load_data_o", exp_data, load_data_o);
            end
            @(posedge clk_i);
            #2;
            load_valid_i = 1'b0;
            // Fresh load fields after acceptance leave only the registered copies in use
            load_op_i     = (op == 2'd2) ? ldu_pkg::LDB : ldu_pkg::LDW;
            load_signed_i = ~sgn;
            load_addr_i   = ~addr;
            cyc++;
            stall_i = (cyc < stall);
        end
        stall_i = 1'b0;
        if (!got) begin
            fault_count++;
            $display("timeout at %0t: no load result for address %h within 200 cycles",
                     $time, addr);
        end
        // The result pulses exactly once
        @(negedge clk_i);
        check_flag("load_data_valid_o", 1'b0, load_data_valid_o);
        @(posedge clk_i);
        #2;
    endtask

    // ----------------------------
    // Pattern replay
    // ----------------------------

    initial begin : main
        int                  fd;
        int                  n;
        int                  cyc;
        int                  stall;
        string               line;
        string               kind;
        logic [1:0]          op;
        logic                sgn;
        logic                priv;
        logic                mis;
        logic                ill;
        ldu_pkg::addr_t      addr;
        ldu_pkg::data_word_t data;

        stall_i          = 1'b0;
        load_valid_i     = 1'b0;
        load_op_i        = ldu_pkg::LDB;
        load_signed_i    = 1'b0;
        load_addr_i      = '0;
        privilege_i      = 1'b0;
        store_valid_i    = 1'b0;
        store_addr_i     = '0;
        store_data_i     = '0;
        mem_load_valid_i = 1'b0;
        mem_load_data_i  = '0;
        mem_store_done_i = 1'b0;

        cyc = 0;
        while (!rst_n_i && cyc < 200) begin
            @(posedge clk_i);
            cyc++;
        end
        if (!rst_n_i) begin
            fault_count++;
            $display("timeout at %0t: reset was never released", $time);
        end
        #2;
        @(negedge clk_i);
        check_flag("idle_o", 1'b1, idle_o);
        check_flag("store_full_o", 1'b0, store_full_o);
        check_flag("load_data_valid_o", 1'b0, load_data_valid_o);
        check_flag("mem_load_req_o", 1'b0, mem_load_req_o);
        check_flag("mem_store_req_o", 1'b0, mem_store_req_o);
        @(posedge clk_i);
        #2;

        fd = $fopen("tb/load_path_patterns.txt", "r");
        if (fd == 0) begin
            fault_count++;
            $display("could not open the pattern file tb/load_path_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 3 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %d",
                            kind, op, sgn, priv, addr, data, mis, ill, stall);
                if (n != 9) begin
                    fault_count++;
                    $display("could not parse pattern line: %s", line);
                end else if (kind == "S") begin
                    run_store(addr, data);
                end else begin
                    run_load(op, sgn, priv, addr, data, mis, ill, stall);
                end
            end
            $fclose(fd);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : load_path_tb

/* tb/load_path_patterns.txt */
# kind op signed priv addr data mis ill stall
# op 0=LDB 1=LDH 2=LDW; data is the store word (S) or the expected result (L)
L 0 0 0 00020204 00000081 0 0 0
L 0 1 0 00020204 ffffff81 0 0 0
L 0 0 0 00020205 00000080 0 0 0
L 0 1 0 00020205 ffffff80 0 0 0
L 0 0 0 00020206 000000a5 0 0 0
L 0 1 0 00020207 ffffffa5 0 0 0
L 1 0 0 00020204 00008081 0 0 0
L 1 1 0 00020204 ffff8081 0 0 0
L 1 0 0 00020206 0000a5a5 0 0 0
L 1 1 0 00020206 ffffa5a5 0 0 0
L 2 0 0 00020204 a5a58081 0 0 0
L 0 1 0 000001fc 0000007f 0 0 0
L 1 0 0 00020205 00000000 1 0 0
L 2 0 0 00020206 00000000 1 0 0
L 2 1 0 0000f010 00000000 0 1 0
L 2 1 1 0000f010 a5a53c04 0 0 0
L 0 0 0 0000ffff 00000000 0 1 0
L 0 0 1 0000ffff 000000a5 0 0 0
L 1 0 0 0000f001 00000000 1 1 0
L 2 0 0 0000effc a5a53bff 0 0 0
L 2 0 0 00020204 a5a58081 0 0 6
L 0 1 0 00020205 ffffff80 0 0 8
S 0 0 0 00000300 11223344 0 0 0
L 2 0 0 00000300 11223344 0 0 0
S 0 0 0 00000300 aaaa0001 0 0 0
S 0 0 0 00000300 bbbb0002 0 0 0
L 2 0 0 00000300 bbbb0002 0 0 0
L 2 0 0 00000300 bbbb0002 0 0 3
S 0 0 0 00000400 cafef00d 0 0 0
S 0 0 0 00000500 deadbeef 0 0 0
L 1 1 0 00000502 ffffdead 0 0 0
L 0 1 0 00000401 fffffff0 0 0 0
S 0 0 0 00000600 01010101 0 0 0
S 0 0 0 00000604 02020202 0 0 0
S 0 0 0 00000608 03030303 0 0 0
S 0 0 0 0000060c 04040404 0 0 0
S 0 0 0 00000610 05050505 0 0 0
L 0 0 0 0000060e 00000004 0 0 0
L 2 0 0 00000610 05050505 0 0 0

/* load_path.f */
common/ldu_pkg.sv
design/load_unit/load_access_check.sv
design/load_unit/load_control.sv
design/load_unit/load_align.sv
design/store_buffer.sv
design/load_path_top.sv
tb/tb_clock_gen.sv
tb/load_path_props.sv
tb/load_path_tb.sv

/* Makefile */
# Verilator build and run of the load path testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module load_path_tb \
		-f load_path.f -o load_path_sim
	./obj_dir/load_path_sim | tee sim.log
	@if grep -q "Finished with no errors" sim.log; then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
